// ==== compile.f ====
hw/raster_pkg.sv
hw/tri_fifo.sv
hw/bbox_filler.sv
hw/axi_tri_regs.sv
hw/draw_controller.sv
hw/frame_buffer.sv
hw/raster_top.sv
verification/tb_raster_top.sv

// ==== Makefile ====
# Verilator build and run of the triangle fill engine testbench

SRCS := $(shell cat compile.f)

obj_dir/Vtb_raster_top: compile.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_raster_top -f compile.f

run: obj_dir/Vtb_raster_top
	obj_dir/Vtb_raster_top | tee sim.log
	grep -q "^Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== verification/tb_raster_top.sv ====
// testbench for the triangle fill engine under Verilator with --timing
// pixels are polled through the scan-out port; clear after reset takes 76800 cycles
// a reference frame store in the testbench follows the bounding-box fill rule
`timescale 1ns/100ps

module tb_raster_top;
  import raster_pkg::*;

  localparam int num_rows    = 10;
  localparam int bus_limit   = 100;
  localparam int pixel_limit = 400000;

  // one stimulus row holds a triangle, its colour, control flags and up to 8 probes
  typedef struct packed {
    logic [2:0][8:0] vx;
    logic [2:0][7:0] vy;
    logic [7:0]      colour;
    logic            vsync;
    logic            hold;
    logic            use_model;
    logic [3:0]      nprobe;
    logic [7:0][8:0] px;
    logic [7:0][7:0] py;
    logic [7:0][7:0] want;
  } row_t;

  logic                    S_AXI_ACLK;
  logic                    S_AXI_ARESETN;
  logic                    vsync;
  logic [9:0]              draw_x;
  logic [9:0]              draw_y;
  logic [axi_addr_w-1:0]   S_AXI_AWADDR;
  logic [2:0]              S_AXI_AWPROT;
  logic                    S_AXI_AWVALID;
  logic                    S_AXI_AWREADY;
  logic [axi_data_w-1:0]   S_AXI_WDATA;
  logic [axi_data_w/8-1:0] S_AXI_WSTRB;
  logic                    S_AXI_WVALID;
  logic                    S_AXI_WREADY;
  logic [1:0]              S_AXI_BRESP;
  logic                    S_AXI_BVALID;
  logic                    S_AXI_BREADY;
  logic [axi_addr_w-1:0]   S_AXI_ARADDR;
  logic [2:0]              S_AXI_ARPROT;
  logic                    S_AXI_ARVALID;
  logic                    S_AXI_ARREADY;
  logic [axi_data_w-1:0]   S_AXI_RDATA;
  logic [1:0]              S_AXI_RRESP;
  logic                    S_AXI_RVALID;
  logic                    S_AXI_RREADY;
  logic [3:0]              red;
  logic [3:0]              green;
  logic [3:0]              blue;

  row_t        rows [num_rows];
  logic [7:0]  ref_fb [fb_height][fb_width];
  logic [31:0] rng;
  int          errors;
  int          checks;
  int          tests;

  raster_top dut0 (.*);

  // 4 ns clock
  always #2 S_AXI_ACLK = ~S_AXI_ACLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // ------------------------------
  // AXI4-Lite bus tasks
  task automatic axi_write(input logic [axi_addr_w-1:0] addr, input logic [31:0] data);
    int n;
    S_AXI_AWADDR  = addr;
    S_AXI_WDATA   = data;
    S_AXI_AWVALID = 1'b1;
    S_AXI_WVALID  = 1'b1;
    S_AXI_BREADY  = 1'b1;
    n = 0;
    while (!S_AXI_AWREADY && n < bus_limit)
    begin
      @(posedge S_AXI_ACLK);
      #1;
      n++;
    end
    if (!S_AXI_AWREADY)
    begin
      $display("timeout: write to address 0x%h was never accepted", addr);
      errors++;
    end
    else
      check_value("WREADY", 32'(S_AXI_WREADY), 32'h1);
    // let the handshake edge pass before dropping the valids
    @(posedge S_AXI_ACLK);
    #1;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WVALID  = 1'b0;
    n = 0;
    while (!S_AXI_BVALID && n < bus_limit)
    begin
      @(posedge S_AXI_ACLK);
      #1;
      n++;
    end
    if (!S_AXI_BVALID)
    begin
      $display("timeout: no write response for address 0x%h", addr);
      errors++;
    end
    else
      check_value("BRESP", 32'(S_AXI_BRESP), 32'h0);
    @(posedge S_AXI_ACLK);
    #1;
    S_AXI_BREADY = 1'b0;
  endtask

  task automatic axi_read(input logic [axi_addr_w-1:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    S_AXI_ARADDR  = addr;
    S_AXI_ARVALID = 1'b1;
    S_AXI_RREADY  = 1'b1;
    n = 0;
    while (!S_AXI_ARREADY && n < bus_limit)
    begin
      @(posedge S_AXI_ACLK);
      #1;
      n++;
    end
    if (!S_AXI_ARREADY)
    begin
      $display("timeout: read of address 0x%h was never accepted", addr);
      errors++;
    end
    @(posedge S_AXI_ACLK);
    #1;
    S_AXI_ARVALID = 1'b0;
    n = 0;
    while (!S_AXI_RVALID && n < bus_limit)
    begin
      @(posedge S_AXI_ACLK);
      #1;
      n++;
    end
    if (!S_AXI_RVALID)
    begin
      $display("timeout: no read data for address 0x%h", addr);
      errors++;
    end
    data = S_AXI_RDATA;
    resp = S_AXI_RRESP;
    @(posedge S_AXI_ACLK);
    #1;
    S_AXI_RREADY = 1'b0;
  endtask

  // ------------------------------
  // reference frame store
  task automatic box_of(input int i, output int lx, output int hx, output int ly, output int hy);
    int x;
    int y;
    lx = int'(rows[i].vx[0]);
    hx = lx;
    ly = int'(rows[i].vy[0]);
    hy = ly;
    for (int k = 1; k < 3; k++)
    begin
      x = int'(rows[i].vx[k]);
      y = int'(rows[i].vy[k]);
      if (x < lx)
        lx = x;
      if (x > hx)
        hx = x;
      if (y < ly)
        ly = y;
      if (y > hy)
        hy = y;
    end
    // both corners clip to the last column and row
    if (lx > fb_width - 1)
      lx = fb_width - 1;
    if (hx > fb_width - 1)
      hx = fb_width - 1;
    if (ly > fb_height - 1)
      ly = fb_height - 1;
    if (hy > fb_height - 1)
      hy = fb_height - 1;
  endtask

  task automatic ref_clear();
    for (int y = 0; y < fb_height; y++)
      for (int x = 0; x < fb_width; x++)
        ref_fb[y][x] = 8'h00;
  endtask

  task automatic ref_fill(input int i);
    int lx;
    int hx;
    int ly;
    int hy;
    box_of(i, lx, hx, ly, hy);
    for (int y = ly; y <= hy; y++)
      for (int x = lx; x <= hx; x++)
        ref_fb[y][x] = rows[i].colour;
  endtask

  // poll the scan-out until the expanded colour shows up
  task automatic probe_pixel(input int px, input int py, input logic [7:0] exp);
    int         n;
    logic [3:0] er;
    logic [3:0] eg;
    logic [3:0] eb;
    er = {exp[7:5], 1'b0};
    eg = {exp[4:2], 1'b0};
    eb = {exp[1:0], 2'b00};
    // odd x exercises the halving of the display coordinate
    draw_x = 10'(2 * px + 1);
    draw_y = 10'(2 * py);
    n = 0;
    do
    begin
      @(posedge S_AXI_ACLK);
      #1;
      n++;
    end
    while ((red !== er || green !== eg || blue !== eb) && n < pixel_limit);
    if (red !== er || green !== eg || blue !== eb)
      $display("timeout: pixel %0d,%0d never showed colour 0x%h", px, py, exp);
    check_value($sformatf("red at %0d,%0d", px, py), 32'(red), 32'(er));
    check_value($sformatf("green at %0d,%0d", px, py), 32'(green), 32'(eg));
    check_value($sformatf("blue at %0d,%0d", px, py), 32'(blue), 32'(eb));
  endtask

  task automatic pulse_vsync();
    vsync = 1'b1;
    repeat (4) @(posedge S_AXI_ACLK);
    #1;
    vsync = 1'b0;
  endtask

  // ------------------------------
  // stimulus table
  task automatic set_row(input int i, input int x0, input int y0, input int x1, input int y1,
                         input int x2, input int y2, input logic [7:0] colour,
                         input logic vs, input logic hold);
    rows[i]        = '0;
    rows[i].vx[0]  = 9'(x0);
    rows[i].vy[0]  = 8'(y0);
    rows[i].vx[1]  = 9'(x1);
    rows[i].vy[1]  = 8'(y1);
    rows[i].vx[2]  = 9'(x2);
    rows[i].vy[2]  = 8'(y2);
    rows[i].colour = colour;
    rows[i].vsync  = vs;
    rows[i].hold   = hold;
  endtask

  task automatic add_probe(input int i, input int x, input int y, input logic [7:0] want);
    rows[i].px[rows[i].nprobe]   = 9'(x);
    rows[i].py[rows[i].nprobe]   = 8'(y);
    rows[i].want[rows[i].nprobe] = want;
    rows[i].nprobe               = rows[i].nprobe + 1'b1;
  endtask

  task automatic build_table();
    int lx;
    int hx;
    int ly;
    int hy;
    // single fill of the box 10..40 by 5..30 with probes one pixel outside each edge
    set_row(0, 10, 20, 40, 5, 25, 30, 8'he5, 1'b0, 1'b0);
    add_probe(0, 10, 5, 8'he5);
    add_probe(0, 40, 30, 8'he5);
    add_probe(0, 25, 17, 8'he5);
    add_probe(0, 9, 17, 8'h00);
    add_probe(0, 41, 17, 8'h00);
    add_probe(0, 25, 4, 8'h00);
    add_probe(0, 25, 31, 8'h00);
    // three overlapping boxes kicked back to back
    set_row(1, 60, 40, 100, 40, 80, 80, 8'h1c, 1'b0, 1'b1);
    set_row(2, 80, 60, 120, 60, 100, 100, 8'he0, 1'b0, 1'b1);
    set_row(3, 90, 70, 110, 70, 100, 90, 8'h03, 1'b0, 1'b0);
    add_probe(3, 95, 75, 8'h03);
    add_probe(3, 100, 70, 8'h03);
    add_probe(3, 85, 65, 8'he0);
    add_probe(3, 115, 95, 8'he0);
    add_probe(3, 65, 45, 8'h1c);
    add_probe(3, 70, 70, 8'h1c);
    add_probe(3, 121, 80, 8'h00);
    // clipped at the right and bottom edge of the screen
    set_row(4, 300, 220, 511, 230, 310, 255, 8'h92, 1'b0, 1'b0);
    add_probe(4, 319, 239, 8'h92);
    add_probe(4, 319, 220, 8'h92);
    add_probe(4, 300, 239, 8'h92);
    add_probe(4, 299, 230, 8'h00);
    add_probe(4, 310, 219, 8'h00);
    // vsync clear and then a new triangle away from the old probes
    set_row(5, 150, 150, 170, 152, 160, 160, 8'h6d, 1'b1, 1'b0);
    add_probe(5, 150, 150, 8'h6d);
    add_probe(5, 170, 160, 8'h6d);
    add_probe(5, 160, 155, 8'h6d);
    add_probe(5, 171, 155, 8'h00);
    add_probe(5, 160, 161, 8'h00);
    // random rows take their expected colours from the reference model
    for (int i = 6; i < num_rows; i++)
    begin
      rows[i] = '0;
      for (int k = 0; k < 3; k++)
      begin
        rng = xorshift32(rng);
        rows[i].vx[k] = rng[8:0];
        rows[i].vy[k] = rng[23:16];
      end
      rng = xorshift32(rng);
      rows[i].colour    = rng[7:0];
      rows[i].use_model = 1'b1;
      box_of(i, lx, hx, ly, hy);
      add_probe(i, lx, ly, 8'h00);
      add_probe(i, hx, hy, 8'h00);
      rng = xorshift32(rng);
      add_probe(i, lx + int'(rng[15:0]) % (hx - lx + 1),
                ly + int'(rng[31:16]) % (hy - ly + 1), 8'h00);
      rng = xorshift32(rng);
      add_probe(i, int'(rng[15:0]) % fb_width, int'(rng[31:16]) % fb_height, 8'h00);
    end
  endtask

  // ------------------------------
  // tests
  task automatic regs_test();
    logic [31:0] rd;
    logic [1:0]  resp;
    int          e0;
    e0 = errors;
    for (int i = 0; i < num_regs; i++)
      if (i != reg_kick)
        axi_write(axi_addr_w'(i * 4), 32'hc3a5_0000 ^ (32'(i) * 32'h0102_0304));
    for (int i = 0; i < num_regs; i++)
    begin
      if (i != reg_kick)
      begin
        axi_read(axi_addr_w'(i * 4), rd, resp);
        check_value($sformatf("RDATA reg %0d", i), rd,
                    32'hc3a5_0000 ^ (32'(i) * 32'h0102_0304));
        check_value("RRESP", 32'(resp), 32'h0);
      end
    end
    tests++;
    $display("test register read-back done, %0d errors", errors - e0);
  endtask

  task automatic apply_row(input int i);
    int         e0;
    logic [7:0] exp;
    e0 = errors;
    if (rows[i].vsync)
    begin
      pulse_vsync();
      ref_clear();
      // every pixel probed so far must go back to black
      for (int j = 0; j < i; j++)
        for (int k = 0; k < rows[j].nprobe; k++)
          probe_pixel(int'(rows[j].px[k]), int'(rows[j].py[k]), 8'h00);
    end
    // vertices go out as x in 8..0 and y in 23..16 before the colour and the kick
    for (int k = 0; k < 3; k++)
      axi_write(axi_addr_w'(k * 4), {8'h00, rows[i].vy[k], 7'h00, rows[i].vx[k]});
    axi_write(axi_addr_w'(12), {24'h0, rows[i].colour});
    axi_write(axi_addr_w'(reg_kick * 4), 32'(i));
    ref_fill(i);
    if (!rows[i].hold)
    begin
      for (int k = 0; k < rows[i].nprobe; k++)
      begin
        exp = rows[i].use_model ? ref_fb[rows[i].py[k]][rows[i].px[k]] : rows[i].want[k];
        probe_pixel(int'(rows[i].px[k]), int'(rows[i].py[k]), exp);
      end
    end
    tests++;
    $display("test row %0d done, %0d probes, %0d errors", i, rows[i].nprobe, errors - e0);
  endtask

  initial
  begin
    S_AXI_ACLK    = 1'b0;
    S_AXI_ARESETN = 1'b0;
    vsync         = 1'b0;
    draw_x        = '0;
    draw_y        = '0;
    S_AXI_AWADDR  = '0;
    S_AXI_AWPROT  = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA   = '0;
    S_AXI_WSTRB   = '1;
    S_AXI_WVALID  = 1'b0;
    S_AXI_BREADY  = 1'b0;
    S_AXI_ARADDR  = '0;
    S_AXI_ARPROT  = '0;
    S_AXI_ARVALID = 1'b0;
    S_AXI_RREADY  = 1'b0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    rng           = 32'ha6a9;
    build_table();
    ref_clear();
    repeat (5) @(posedge S_AXI_ACLK);
    #1;
    S_AXI_ARESETN = 1'b1;
    // outputs must be idle right after reset
    check_value("AWREADY", 32'(S_AXI_AWREADY), 32'h0);
    check_value("WREADY", 32'(S_AXI_WREADY), 32'h0);
    check_value("BVALID", 32'(S_AXI_BVALID), 32'h0);
    check_value("ARREADY", 32'(S_AXI_ARREADY), 32'h0);
    check_value("RVALID", 32'(S_AXI_RVALID), 32'h0);
    regs_test();
    for (int i = 0; i < num_rows; i++)
      apply_row(i);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== hw/raster_top.sv ====
// triangle fill engine behind an AXI4-Lite slave
// WSTRB, AWPROT and ARPROT are accepted but not used
// vsync may be asynchronous, draw_x/draw_y must be in the bus clock domain
`timescale 1ns/100ps

module raster_top
(
  input  logic                              S_AXI_ACLK,
  input  logic                              S_AXI_ARESETN,
  input  logic                              vsync,
  input  logic [9:0]                        draw_x,
  input  logic [9:0]                        draw_y,
  input  logic [raster_pkg::axi_addr_w-1:0] S_AXI_AWADDR,
  input  logic [2:0]                        S_AXI_AWPROT,
  input  logic                              S_AXI_AWVALID,
  output logic                              S_AXI_AWREADY,
  input  logic [raster_pkg::axi_data_w-1:0] S_AXI_WDATA,
  input  logic [raster_pkg::axi_data_w/8-1:0] S_AXI_WSTRB,
  input  logic                              S_AXI_WVALID,
  output logic                              S_AXI_WREADY,
  output logic [1:0]                        S_AXI_BRESP,
  output logic                              S_AXI_BVALID,
  input  logic                              S_AXI_BREADY,
  input  logic [raster_pkg::axi_addr_w-1:0] S_AXI_ARADDR,
  input  logic [2:0]                        S_AXI_ARPROT,
  input  logic                              S_AXI_ARVALID,
  output logic                              S_AXI_ARREADY,
  output logic [raster_pkg::axi_data_w-1:0] S_AXI_RDATA,
  output logic [1:0]                        S_AXI_RRESP,
  output logic                              S_AXI_RVALID,
  input  logic                              S_AXI_RREADY,
  output logic [3:0]                        red,
  output logic [3:0]                        green,
  output logic [3:0]                        blue
);
  import raster_pkg::*;

  // queue side
  logic                 push;
  logic                 full;
  logic                 empty;
  logic                 pop;
  tri_t                 tri_in;
  tri_t                 tri_out;
  // frame store write port
  logic                 we;
  logic [fb_addr_w-1:0] waddr;
  colour_t              wdata;

  axi_tri_regs regs0
  (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .S_AXI_AWADDR, .S_AXI_AWVALID, .S_AXI_AWREADY,
    .S_AXI_WDATA, .S_AXI_WVALID, .S_AXI_WREADY,
    .S_AXI_BRESP, .S_AXI_BVALID, .S_AXI_BREADY,
    .S_AXI_ARADDR, .S_AXI_ARVALID, .S_AXI_ARREADY,
    .S_AXI_RDATA, .S_AXI_RRESP, .S_AXI_RVALID, .S_AXI_RREADY,
    .full, .push, .tri_in
  );

  tri_fifo #(.payload_t(tri_t), .depth(tri_fifo_depth)) fifo0
  (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .push, .din(tri_in), .pop,
    .dout(tri_out), .full, .empty
  );

  draw_controller ctrl0
  (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .vsync, .empty, .tri_out, .pop,
    .we, .waddr, .wdata
  );

  frame_buffer fb0
  (
    .S_AXI_ACLK, .we, .waddr, .wdata,
    .draw_x, .draw_y, .red, .green, .blue
  );

endmodule

// ==== hw/frame_buffer.sv ====
// 320x240 byte frame store with one write port and one scan-out port
// scan-out halves the 640x480 display coordinates
// addresses past the store read back as black
`timescale 1ns/100ps

module frame_buffer
(
  input  logic                             S_AXI_ACLK,
  input  logic                             we,
  input  logic [raster_pkg::fb_addr_w-1:0] waddr,
  input  raster_pkg::colour_t              wdata,
  input  logic [9:0]                       draw_x,
  input  logic [9:0]                       draw_y,
  output logic [3:0]                       red,
  output logic [3:0]                       green,
  output logic [3:0]                       blue
);
  import raster_pkg::*;

  colour_t              mem [fb_depth];
  // one bit wider than the store address so that large coordinates do not wrap
  logic [fb_addr_w:0]   raddr;
  colour_t              pix;

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (we)
      mem[waddr] <= wdata;
  end

  // each stored pixel covers a 2x2 block of the display
  assign raddr = (fb_addr_w+1)'(draw_y[9:1]) * (fb_addr_w+1)'(fb_width)
               + (fb_addr_w+1)'(draw_x[9:1]);

  // registered read so the colour appears one clock after draw_x and draw_y
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (raddr < (fb_addr_w+1)'(fb_depth))
      pix <= mem[raddr[fb_addr_w-1:0]];
    else
      pix <= '0;
  end

  // 3-3-2 widened to 4 bits per channel with zero low bits
  assign red   = {pix.r, 1'b0};
  assign green = {pix.g, 1'b0};
  assign blue  = {pix.b, 2'b00};

endmodule

// ==== hw/draw_controller.sv ====
// clears the frame store after reset and on each vsync rising edge,
// then fills queued triangles one at a time
// a vsync edge abandons the running fill; queued triangles are kept
`timescale 1ns/100ps

module draw_controller
(
  input  logic                             S_AXI_ACLK,
  input  logic                             S_AXI_ARESETN,
  input  logic                             vsync,
  input  logic                             empty,
  input  raster_pkg::tri_t                 tri_out,
  output logic                             pop,
  output logic                             we,
  output logic [raster_pkg::fb_addr_w-1:0] waddr,
  output raster_pkg::colour_t              wdata
);
  import raster_pkg::*;

  draw_state_t          state;
  logic [fb_addr_w-1:0] clear_addr;
  logic                 vsync_s1;
  logic                 vsync_s2;
  logic                 vsync_d;
  logic                 vsync_rise;
  logic                 fill_rst_n;
  logic                 fill_we;
  logic [fb_addr_w-1:0] fill_addr;
  colour_t              fill_colour;
  logic                 done;

  // ------------------------------
  // vsync comes from the video clock domain, two flop synchroniser
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      vsync_s1 <= 1'b0;
      vsync_s2 <= 1'b0;
      vsync_d  <= 1'b0;
    end
    else
    begin
      vsync_s1 <= vsync;
      vsync_s2 <= vsync_s1;
      vsync_d  <= vsync_s2;
    end
  end

  assign vsync_rise = vsync_s2 && !vsync_d;

  // take the head as soon as it is there; pop doubles as the filler start
  assign pop = (state == wait_tri) && !empty && !vsync_rise;

  // ------------------------------
  // state machine
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN || vsync_rise)
    begin
      state      <= clear_buf;
      clear_addr <= '0;
    end
    else
    begin
      case (state)
        clear_buf:
        begin
          // one address per cycle over the whole store
          if (clear_addr == fb_addr_w'(fb_depth - 1))
          begin
            clear_addr <= '0;
            state      <= wait_tri;
          end
          else
            clear_addr <= clear_addr + 1'b1;
        end
        wait_tri:
          if (!empty)
            state <= fill_tri;
        fill_tri:
          if (done)
            state <= wait_tri;
        default:
          state <= clear_buf;
      endcase
    end
  end

  // filler is reset on vsync so an abandoned fill stops writing
  assign fill_rst_n = S_AXI_ARESETN && !vsync_rise;

  bbox_filler filler0
  (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (fill_rst_n),
    .start         (pop),
    .tri_in        (tri_out),
    .fill_we       (fill_we),
    .fill_addr     (fill_addr),
    .fill_colour   (fill_colour),
    .done          (done)
  );

  // frame store port, clear counter or filler
  always_comb
  begin
    if (state == clear_buf)
    begin
      we    = 1'b1;
      waddr = clear_addr;
      wdata = clear_colour;
    end
    else
    begin
      we    = fill_we;
      waddr = fill_addr;
      wdata = fill_colour;
    end
  end

endmodule

// ==== hw/axi_tri_regs.sv ====
// AXI4-Lite slave with 8 word registers, one write outstanding at a time
// byte strobes and protection bits are not used, all writes are full words
// reading register 4 returns the queue full flag in bit 31
// a kick is pushed even when the queue is full; the queue drops it
`timescale 1ns/100ps

module axi_tri_regs
(
  input  logic                                 S_AXI_ACLK,
  input  logic                                 S_AXI_ARESETN,
  input  logic [raster_pkg::axi_addr_w-1:0]    S_AXI_AWADDR,
  input  logic                                 S_AXI_AWVALID,
  output logic                                 S_AXI_AWREADY,
  input  logic [raster_pkg::axi_data_w-1:0]    S_AXI_WDATA,
  input  logic                                 S_AXI_WVALID,
  output logic                                 S_AXI_WREADY,
  output logic [1:0]                           S_AXI_BRESP,
  output logic                                 S_AXI_BVALID,
  input  logic                                 S_AXI_BREADY,
  input  logic [raster_pkg::axi_addr_w-1:0]    S_AXI_ARADDR,
  input  logic                                 S_AXI_ARVALID,
  output logic                                 S_AXI_ARREADY,
  output logic [raster_pkg::axi_data_w-1:0]    S_AXI_RDATA,
  output logic [1:0]                           S_AXI_RRESP,
  output logic                                 S_AXI_RVALID,
  input  logic                                 S_AXI_RREADY,
  input  logic                                 full,
  output logic                                 push,
  output raster_pkg::tri_t                     tri_in
);
  import raster_pkg::*;

  logic [axi_data_w-1:0] slv_regs [num_regs];
  logic [axi_addr_w-1:0] axi_awaddr;
  logic [axi_addr_w-1:0] axi_araddr;
  logic [axi_addr_w-3:0] wr_idx;
  logic [axi_addr_w-3:0] rd_idx;
  logic [axi_data_w-1:0] rd_word;
  // one flop drives both AWREADY and WREADY
  logic                  wr_ready;
  logic                  aw_en;
  logic                  wr_fire;

  // word index, the two low address bits select a byte
  assign wr_idx = axi_awaddr[axi_addr_w-1:2];
  assign rd_idx = axi_araddr[axi_addr_w-1:2];

  assign S_AXI_AWREADY = wr_ready;
  assign S_AXI_WREADY  = wr_ready;
  // every response is OKAY
  assign S_AXI_BRESP   = 2'b00;
  assign S_AXI_RRESP   = 2'b00;

  // ------------------------------
  // write channel
  // address and data are taken together; aw_en holds off the next
  // write until the response has been accepted
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      wr_ready <= 1'b0;
      aw_en    <= 1'b1;
    end
    else if (!wr_ready && S_AXI_AWVALID && S_AXI_WVALID && aw_en)
    begin
      wr_ready <= 1'b1;
      aw_en    <= 1'b0;
    end
    else
    begin
      wr_ready <= 1'b0;
      if (S_AXI_BREADY && S_AXI_BVALID)
        aw_en <= 1'b1;
    end
  end

  // latch the write address for the data cycle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!wr_ready && S_AXI_AWVALID && S_AXI_WVALID && aw_en)
      axi_awaddr <= S_AXI_AWADDR;
  end

  assign wr_fire = wr_ready && S_AXI_AWVALID && S_AXI_WVALID;

  // register file and the triangle push
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      push <= 1'b0;
      for (int i = 0; i < num_regs; i++)
        slv_regs[i] <= '0;
    end
    else
    begin
      push <= 1'b0;
      if (wr_fire)
      begin
        slv_regs[wr_idx] <= S_AXI_WDATA;
        if (wr_idx == (axi_addr_w-2)'(reg_kick))
          push <= 1'b1;
      end
    end
  end

  // pack vertices and colour from registers 0 to 3, lands with push
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (wr_fire)
    begin
      for (int i = 0; i < 3; i++)
      begin
        tri_in.v[i].x <= slv_regs[i][8:0];
        tri_in.v[i].y <= slv_regs[i][23:16];
      end
      tri_in.colour <= slv_regs[3][7:0];
    end
  end

  // write response, held until BREADY
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      S_AXI_BVALID <= 1'b0;
    else if (wr_fire && !S_AXI_BVALID)
      S_AXI_BVALID <= 1'b1;
    else if (S_AXI_BREADY && S_AXI_BVALID)
      S_AXI_BVALID <= 1'b0;
  end

  // ------------------------------
  // read channel
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      S_AXI_ARREADY <= 1'b0;
    else
      S_AXI_ARREADY <= !S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID;
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID)
      axi_araddr <= S_AXI_ARADDR;
  end

  // kick register shows queue status in its top bit
  always_comb
  begin
    rd_word = slv_regs[rd_idx];
    if (rd_idx == (axi_addr_w-2)'(reg_kick))
      rd_word[axi_data_w-1] = full;
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      S_AXI_RVALID <= 1'b0;
    else if (S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID)
      S_AXI_RVALID <= 1'b1;
    else if (S_AXI_RVALID && S_AXI_RREADY)
      S_AXI_RVALID <= 1'b0;
  end

  // data held stable while RVALID waits for RREADY
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID)
      S_AXI_RDATA <= rd_word;
  end

endmodule

// ==== hw/bbox_filler.sv ====
// fills the bounding box of a triangle with its colour, row by row
// box corners are clipped to 319 and 239, both min and max
// one pixel per cycle, start is ignored-safe only when idle
`timescale 1ns/100ps

module bbox_filler
(
  input  logic                             S_AXI_ACLK,
  input  logic                             S_AXI_ARESETN,
  input  logic                             start,
  input  raster_pkg::tri_t                 tri_in,
  output logic                             fill_we,
  output logic [raster_pkg::fb_addr_w-1:0] fill_addr,
  output raster_pkg::colour_t              fill_colour,
  output logic                             done
);
  import raster_pkg::*;

  vx_t  lo_x;
  vx_t  hi_x;
  vy_t  lo_y;
  vy_t  hi_y;
  vx_t  x_min;
  vx_t  x_max;
  vy_t  y_max;
  vx_t  x_cnt;
  vy_t  y_cnt;
  logic busy;
  logic last;

  // min and max over the three vertices, then clip to the screen
  always_comb
  begin
    lo_x = tri_in.v[0].x;
    hi_x = tri_in.v[0].x;
    lo_y = tri_in.v[0].y;
    hi_y = tri_in.v[0].y;
    for (int i = 1; i < 3; i++)
    begin
      if (tri_in.v[i].x < lo_x) lo_x = tri_in.v[i].x;
      if (tri_in.v[i].x > hi_x) hi_x = tri_in.v[i].x;
      if (tri_in.v[i].y < lo_y) lo_y = tri_in.v[i].y;
      if (tri_in.v[i].y > hi_y) hi_y = tri_in.v[i].y;
    end
    if (lo_x > vx_t'(fb_width - 1)) lo_x = vx_t'(fb_width - 1);
    if (hi_x > vx_t'(fb_width - 1)) hi_x = vx_t'(fb_width - 1);
    if (lo_y > vy_t'(fb_height - 1)) lo_y = vy_t'(fb_height - 1);
    if (hi_y > vy_t'(fb_height - 1)) hi_y = vy_t'(fb_height - 1);
  end

  assign last = (x_cnt == x_max) && (y_cnt == y_max);

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      busy <= 1'b0;
    else if (start)
      busy <= 1'b1;
    else if (busy && last)
      busy <= 1'b0;
  end

  // box registered on start, then x runs fastest
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (start)
    begin
      x_min       <= lo_x;
      x_max       <= hi_x;
      y_max       <= hi_y;
      x_cnt       <= lo_x;
      y_cnt       <= lo_y;
      fill_colour <= tri_in.colour;
    end
    else if (busy)
    begin
      if (x_cnt == x_max)
      begin
        x_cnt <= x_min;
        y_cnt <= y_cnt + 1'b1;
      end
      else
        x_cnt <= x_cnt + 1'b1;
    end
  end

  assign fill_we   = busy;
  assign done      = busy && last;
  // row-major address
  assign fill_addr = fb_addr_w'(y_cnt) * fb_addr_w'(fb_width) + fb_addr_w'(x_cnt);

endmodule

// ==== hw/tri_fifo.sv ====
// single clock queue for any payload type, head always shown on dout
// push when full and pop when empty are dropped
// depth must be at least 2
`timescale 1ns/100ps

module tri_fifo
#(
  parameter type payload_t = logic,
  parameter int  depth     = 16
)
(
  input  logic     S_AXI_ACLK,
  input  logic     S_AXI_ARESETN,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     full,
  output logic     empty
);

  payload_t                   mem [depth];
  logic [$clog2(depth)-1:0]   wr_ptr;
  logic [$clog2(depth)-1:0]   rd_ptr;
  logic [$clog2(depth+1)-1:0] count;
  logic                       do_push;
  logic                       do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full  = count == ($clog2(depth+1))'(depth);
  assign empty = count == '0;
  // show-ahead head
  assign dout  = mem[rd_ptr];

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

  // pointers wrap at depth, count tracks occupancy
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == ($clog2(depth))'(depth-1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == ($clog2(depth))'(depth-1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

// ==== hw/raster_pkg.sv ====
// shared constants and types for the triangle fill engine
// frame store is 320x240 bytes, one byte per pixel in 3-3-2 colour
// vertex coordinates are unsigned; no sub-pixel precision

package raster_pkg;

  // ------------------------------
  // bus and register file
  localparam int axi_addr_w = 5;
  localparam int axi_data_w = 32;
  localparam int num_regs   = 8;
  // a write here pushes the triangle held in registers 0 to 3
  localparam int reg_kick   = 4;

  // ------------------------------
  // frame store geometry
  localparam int fb_width  = 320;
  localparam int fb_height = 240;
  localparam int fb_depth  = fb_width * fb_height;
  localparam int fb_addr_w = 17;

  // triangle queue
  localparam int tri_fifo_depth = 16;

  // ------------------------------
  // pixel and vertex types
  typedef logic [8:0] vx_t;
  typedef logic [7:0] vy_t;

  // 3 bits red, 3 bits green, 2 bits blue
  typedef struct packed {
    logic [2:0] r;
    logic [2:0] g;
    logic [1:0] b;
  } colour_t;

  typedef struct packed {
    vx_t x;
    vy_t y;
  } vertex_t;

  // v[0] comes from register 0, v[2] from register 2
  typedef struct packed {
    vertex_t [2:0] v;
    colour_t       colour;
  } tri_t;

  typedef enum logic [1:0] {clear_buf, wait_tri, fill_tri} draw_state_t;

  // value written to every pixel during a clear
  localparam colour_t clear_colour = '0;

endpackage
